// ==== mouse_pad_top.f ====
hdl/mouse_pad_pkg.sv
hdl/ps2_receiver.sv
hdl/mouse_packet_assembler.sv
hdl/packet_fifo.sv
hdl/canvas_painter.sv
hdl/mouse_pad_top.sv
verification/mouse_pad_tb.sv

// ==== Makefile ====
# Verilator build for the PS/2 mouse drawing pad

SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := mouse_pad_tb
FILELIST := mouse_pad_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/mouse_pad_tb.sv ====
`timescale 1ns/10ps

module mouse_pad_tb;

    localparam int PS2_HALF     = 20;  // CLOCK_50 cycles per PS/2 clock phase
    localparam int NUM_PACKETS  = 55;  // Tests 2 to 5, aborted packet included
    localparam int WATCHDOG_CYC = NUM_PACKETS * 3 * 11 * 2 * PS2_HALF + 10000;
    localparam int CHECK_CURSOR = 1;
    localparam int CHECK_PIXEL  = 2;
    localparam int X_END = mouse_pad_pkg::GRID_X0
                         + mouse_pad_pkg::GRID_SIZE * mouse_pad_pkg::PIXEL_SCALE;
    localparam int Y_END = mouse_pad_pkg::GRID_Y0
                         + mouse_pad_pkg::GRID_SIZE * mouse_pad_pkg::PIXEL_SCALE;

    logic       CLOCK_50;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] pix_x;
    logic [6:0] pix_y;
    logic [2:0] pix_colour;
    logic [7:0] cursor_x;
    logic [6:0] cursor_y;
    logic       frame_error;

    int     model_x;
    int     model_y;
    bit     model_canvas [mouse_pad_pkg::GRID_SIZE][mouse_pad_pkg::GRID_SIZE];  // [row][col]
    int     check_kind;  // Request to the compare process, 0 when idle
    int     cursor_errors;
    int     colour_errors;
    int     frame_errors;
    int     frame_pulses;
    integer seed;

    mouse_pad_top u_mouse_pad_top (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_colour  (pix_colour),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .frame_error (frame_error)
    );

    always #2 CLOCK_50 = ~CLOCK_50;

    function automatic bit in_canvas(input int x, input int y);
        return x >= mouse_pad_pkg::GRID_X0 && x < X_END
            && y >= mouse_pad_pkg::GRID_Y0 && y < Y_END;
    endfunction

    // Model of one packet: move, clamp to the screen, paint under the new cursor
    function automatic void apply_move(input bit left, input logic signed [8:0] dx,
                                       input logic signed [8:0] dy);
        int         nx;
        int         ny;
        logic [4:0] col;
        logic [4:0] row;
        nx = model_x + int'(dx);
        ny = model_y + int'(dy);
        if (nx < 0) begin
            nx = 0;
        end else if (nx > mouse_pad_pkg::SCREEN_W - 1) begin
            nx = mouse_pad_pkg::SCREEN_W - 1;
        end
        if (ny < 0) begin
            ny = 0;
        end else if (ny > mouse_pad_pkg::SCREEN_H - 1) begin
            ny = mouse_pad_pkg::SCREEN_H - 1;
        end
        model_x = nx;
        model_y = ny;
        col = 5'((nx - mouse_pad_pkg::GRID_X0) / mouse_pad_pkg::PIXEL_SCALE);
        row = 5'((ny - mouse_pad_pkg::GRID_Y0) / mouse_pad_pkg::PIXEL_SCALE);
        if (left && in_canvas(nx, ny)) begin
            model_canvas[row][col] = 1'b1;
        end
    endfunction

    function automatic logic [2:0] expected_colour(input logic [7:0] x, input logic [6:0] y);
        int         xi;
        int         yi;
        logic [4:0] col;
        logic [4:0] row;
        xi  = int'(x);
        yi  = int'(y);
        col = 5'((xi - mouse_pad_pkg::GRID_X0) / mouse_pad_pkg::PIXEL_SCALE);
        row = 5'((yi - mouse_pad_pkg::GRID_Y0) / mouse_pad_pkg::PIXEL_SCALE);
        if (xi == model_x && yi == model_y) begin
            return mouse_pad_pkg::COLOUR_CURSOR;
        end else if (in_canvas(xi, yi) && model_canvas[row][col]) begin
            return mouse_pad_pkg::COLOUR_INK;
        end
        return mouse_pad_pkg::COLOUR_PAPER;
    endfunction

    task automatic check_cursor(input logic [7:0] got_x, input logic [6:0] got_y,
                                input logic [7:0] exp_x, input logic [6:0] exp_y);
        if (got_x !== exp_x || got_y !== exp_y) begin
            cursor_errors++;
            $display("[FAIL] %0t: cursor at (%0d,%0d), expected (%0d,%0d)",
                     $time, got_x, got_y, exp_x, exp_y);
        end
    endtask

    task automatic check_colour(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            colour_errors++;
            $display("[FAIL] %0t: pixel (%0d,%0d) colour %b, expected %b",
                     $time, pix_x, pix_y, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;  // Inputs move just after the edge
    endtask

    // One 11-bit PS/2 frame, device side, LSB first
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^data;
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, data, 1'b0};
        repeat (11) begin
            ps2_data = frame[0];
            frame    = frame >> 1;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;  // Receiver samples here
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
    endtask

    task automatic request_check(input int kind);
        check_kind = kind;
        wait (check_kind == 0);
    endtask

    task automatic send_packet(input bit left, input logic signed [8:0] dx,
                               input logic signed [8:0] dy);
        logic [7:0] status;
        status = {2'b00, dy[8], dx[8], 1'b1, 2'b00, left};
        send_frame(status, 1'b0);
        send_frame(dx[7:0], 1'b0);
        send_frame(dy[7:0], 1'b0);
        apply_move(left, dx, dy);
        request_check(CHECK_CURSOR);
    endtask

    task automatic probe_pixel(input logic [7:0] x, input logic [6:0] y);
        pix_x = x;
        pix_y = y;
        request_check(CHECK_PIXEL);
    endtask

    // All four screen pixels of one canvas cell
    task automatic probe_cell(input int col, input int row);
        for (int oy = 0; oy < mouse_pad_pkg::PIXEL_SCALE; oy++) begin
            for (int ox = 0; ox < mouse_pad_pkg::PIXEL_SCALE; ox++) begin
                probe_pixel(8'(mouse_pad_pkg::GRID_X0 + col * mouse_pad_pkg::PIXEL_SCALE + ox),
                            7'(mouse_pad_pkg::GRID_Y0 + row * mouse_pad_pkg::PIXEL_SCALE + oy));
            end
        end
    endtask

    // Compare process, serves the requests of the stimulus
    initial begin : compare_proc
        int waited;
        forever begin
            wait (check_kind != 0);
            if (check_kind == CHECK_CURSOR) begin
                waited = 0;  // Chain latency varies, so poll with a limit
                while ((int'(cursor_x) != model_x || int'(cursor_y) != model_y)
                       && waited < 40) begin
                    @(posedge CLOCK_50);
                    #1;
                    waited++;
                end
                check_cursor(cursor_x, cursor_y, 8'(model_x), 7'(model_y));
            end else begin
                @(posedge CLOCK_50);  // pix_colour is registered
                #1;
                check_colour(pix_colour, expected_colour(pix_x, pix_y));
            end
            check_kind = 0;
        end
    end

    always @(posedge CLOCK_50) begin
        if (!reset && frame_error) begin
            frame_pulses++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge CLOCK_50);
        $display("Watchdog timeout after %0d cycles, the tests did not finish", WATCHDOG_CYC);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main_seq
        int                pulses_before;
        bit                left;
        logic signed [8:0] dx;
        logic signed [8:0] dy;
        CLOCK_50      = 1'b0;
        reset         = 1'b1;
        ps2_clk       = 1'b1;
        ps2_data      = 1'b1;
        pix_x         = '0;
        pix_y         = '0;
        check_kind    = 0;
        cursor_errors = 0;
        colour_errors = 0;
        frame_errors  = 0;
        frame_pulses  = 0;
        seed          = 32'h03727a18;
        model_x       = mouse_pad_pkg::CURSOR_X0;
        model_y       = mouse_pad_pkg::CURSOR_Y0;
        repeat (8) @(posedge CLOCK_50);
        #1;
        reset = 1'b0;

        // Test 1, state after reset
        request_check(CHECK_CURSOR);
        probe_pixel(8'd80, 7'd60);
        probe_pixel(8'd52, 7'd32);
        probe_pixel(8'd107, 7'd87);
        probe_pixel(8'd81, 7'd60);
        probe_pixel(8'd0, 7'd0);
        probe_pixel(8'd159, 7'd119);

        // Test 2, moves and clamping, button up
        send_packet(1'b0, 9'sd10, 9'sd5);
        send_packet(1'b0, -9'sd30, -9'sd20);
        send_packet(1'b0, 9'sd255, 9'sd0);   // Clamps at 159
        send_packet(1'b0, 9'sd0, 9'sd100);   // Clamps at 119
        send_packet(1'b0, 9'h100, 9'h100);   // Largest negative move
        send_packet(1'b0, 9'sd80, 9'sd60);

        // Test 3, painting inside and outside the canvas
        send_packet(1'b1, -9'sd20, -9'sd20);
        send_packet(1'b1, 9'sd1, 9'sd0);
        send_packet(1'b1, 9'sd10, 9'sd10);
        send_packet(1'b1, -9'sd60, 9'sd0);   // Off the canvas
        send_packet(1'b0, 9'sd50, 9'sd20);   // Button up
        send_packet(1'b1, 9'sd46, 9'sd17);   // Last cell
        probe_cell(4, 4);
        probe_cell(9, 9);
        probe_cell(27, 27);
        probe_cell(4, 19);
        probe_pixel(8'd11, 7'd50);
        probe_pixel(8'd108, 7'd87);

        // Test 4, bad parity on a status byte, then stray bytes without bit 3
        pulses_before = frame_pulses;
        send_frame(8'h09, 1'b1);
        if (frame_pulses != pulses_before + 1) begin
            frame_errors++;
            $display("frame_error did not pulse for a frame with bad parity");
        end
        send_frame(8'h05, 1'b0);
        send_frame(8'h02, 1'b0);
        request_check(CHECK_CURSOR);  // Nothing may have moved
        send_packet(1'b1, -9'sd50, -9'sd40);
        send_packet(1'b0, 9'sd3, 9'sd3);
        probe_cell(2, 7);

        // Test 5, random walk with an occasional large jump
        for (int i = 0; i < 40; i++) begin
            left = ($random(seed) % 4) != 0;
            if (i % 10 == 9) begin
                dx = 9'($random(seed));
                dy = 9'($random(seed));
            end else begin
                dx = 9'($random(seed) % 12);
                dy = 9'($random(seed) % 12);
            end
            send_packet(left, dx, dy);
        end
        for (int y = mouse_pad_pkg::GRID_Y0; y < Y_END; y++) begin
            for (int x = mouse_pad_pkg::GRID_X0; x < X_END; x++) begin
                probe_pixel(8'(x), 7'(y));
            end
        end
        probe_pixel(cursor_x, cursor_y);  // Cursor may sit off the canvas

        if (frame_pulses != 1) begin
            frame_errors++;
            $display("frame_error pulsed %0d times over the run instead of once", frame_pulses);
        end
        $display("Errors: cursor %0d, colour %0d, frame %0d",
                 cursor_errors, colour_errors, frame_errors);
        if (cursor_errors + colour_errors + frame_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== hdl/mouse_pad_top.sv ====
`timescale 1ns/10ps

module mouse_pad_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic [7:0] pix_x,
    input  logic [6:0] pix_y,
    output logic [2:0] pix_colour,
    output logic [7:0] cursor_x,
    output logic [6:0] cursor_y,
    output logic       frame_error
);

    logic [7:0]                   byte_data;
    logic                         byte_valid;
    logic                         push;
    mouse_pad_pkg::mouse_packet_t packet_in;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_ack;
    mouse_pad_pkg::mouse_packet_t wb_dat;

    ps2_receiver u_ps2_receiver (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_data   (byte_data),
        .byte_valid  (byte_valid),
        .frame_error (frame_error)
    );

    mouse_packet_assembler u_mouse_packet_assembler (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .push       (push),
        .packet_in  (packet_in)
    );

    packet_fifo #(
        .payload_t (mouse_pad_pkg::mouse_packet_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_packet_fifo (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .push      (push),
        .packet_in (packet_in),
        .full      (),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .wb_dat    (wb_dat)
    );

    canvas_painter u_canvas_painter (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y)
    );

endmodule

// ==== hdl/canvas_painter.sv ====
`timescale 1ns/10ps

module canvas_painter (
    input  logic                        CLOCK_50,
    input  logic                        reset,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    input  logic                        wb_ack,
    input  mouse_pad_pkg::mouse_packet_t wb_dat,
    input  logic [7:0]                  pix_x,
    input  logic [6:0]                  pix_y,
    output logic [2:0]                  pix_colour,
    output logic [7:0]                  cursor_x,
    output logic [6:0]                  cursor_y
);

    localparam int GW    = $clog2(mouse_pad_pkg::GRID_SIZE);
    localparam int SPAN  = mouse_pad_pkg::GRID_SIZE * mouse_pad_pkg::PIXEL_SCALE;
    localparam int X_END = mouse_pad_pkg::GRID_X0 + SPAN;  // First column past the canvas
    localparam int Y_END = mouse_pad_pkg::GRID_Y0 + SPAN;

    logic                                 req;
    logic [mouse_pad_pkg::GRID_SIZE-1:0] canvas [mouse_pad_pkg::GRID_SIZE];  // Row per y cell
    logic signed [10:0]                   sum_x;
    logic signed [10:0]                   sum_y;
    logic [7:0]                           next_x;
    logic [6:0]                           next_y;
    logic                                 paint;
    logic [GW-1:0]                        paint_col;
    logic [GW-1:0]                        paint_row;
    logic                                 pix_in_canvas;
    logic [GW-1:0]                        pix_col;
    logic [GW-1:0]                        pix_row;

    // Single request line drives cyc and stb together
    assign wb_cyc = req;
    assign wb_stb = req;

    // Drop for one cycle after each ack, then ask again
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            req <= 1'b0;
        end else begin
            req <= !wb_ack;
        end
    end

    // Move and clamp
    always_comb begin
        sum_x = $signed({3'b000, cursor_x}) + $signed({{2{wb_dat.dx[8]}}, wb_dat.dx});
        sum_y = $signed({4'b0000, cursor_y}) + $signed({{2{wb_dat.dy[8]}}, wb_dat.dy});
        if (sum_x < 0) begin
            next_x = '0;
        end else if (sum_x > mouse_pad_pkg::SCREEN_W - 1) begin
            next_x = 8'(mouse_pad_pkg::SCREEN_W - 1);
        end else begin
            next_x = sum_x[7:0];
        end
        if (sum_y < 0) begin
            next_y = '0;
        end else if (sum_y > mouse_pad_pkg::SCREEN_H - 1) begin
            next_y = 7'(mouse_pad_pkg::SCREEN_H - 1);
        end else begin
            next_y = sum_y[6:0];
        end
    end

    // Cell under the new cursor position
    assign paint = wb_dat.left
                && int'(next_x) >= mouse_pad_pkg::GRID_X0 && int'(next_x) < X_END
                && int'(next_y) >= mouse_pad_pkg::GRID_Y0 && int'(next_y) < Y_END;
    assign paint_col = GW'((int'(next_x) - mouse_pad_pkg::GRID_X0) / mouse_pad_pkg::PIXEL_SCALE);
    assign paint_row = GW'((int'(next_y) - mouse_pad_pkg::GRID_Y0) / mouse_pad_pkg::PIXEL_SCALE);

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            cursor_x <= 8'(mouse_pad_pkg::CURSOR_X0);
            cursor_y <= 7'(mouse_pad_pkg::CURSOR_Y0);
            for (int r = 0; r < mouse_pad_pkg::GRID_SIZE; r++) begin
                canvas[r] <= '0;  // Blank canvas
            end
        end else if (wb_ack) begin
            cursor_x <= next_x;
            cursor_y <= next_y;
            if (paint) begin
                canvas[paint_row][paint_col] <= 1'b1;
            end
        end
    end

    // Pixel lookup
    assign pix_in_canvas = int'(pix_x) >= mouse_pad_pkg::GRID_X0 && int'(pix_x) < X_END
                        && int'(pix_y) >= mouse_pad_pkg::GRID_Y0 && int'(pix_y) < Y_END;
    assign pix_col = GW'((int'(pix_x) - mouse_pad_pkg::GRID_X0) / mouse_pad_pkg::PIXEL_SCALE);
    assign pix_row = GW'((int'(pix_y) - mouse_pad_pkg::GRID_Y0) / mouse_pad_pkg::PIXEL_SCALE);

    always_ff @(posedge CLOCK_50) begin
        if (pix_x == cursor_x && pix_y == cursor_y) begin
            pix_colour <= mouse_pad_pkg::COLOUR_CURSOR;  // Cursor wins over ink
        end else if (pix_in_canvas && canvas[pix_row][pix_col]) begin
            pix_colour <= mouse_pad_pkg::COLOUR_INK;
        end else begin
            pix_colour <= mouse_pad_pkg::COLOUR_PAPER;
        end
    end

endmodule

// ==== hdl/packet_fifo.sv ====
`timescale 1ns/10ps

module packet_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     CLOCK_50,
    input  logic     reset,
    input  logic     push,
    input  payload_t packet_in,
    output logic     full,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    output logic     wb_ack,
    output payload_t wb_dat
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            empty;
    logic            do_push;
    logic            do_pop;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;  // Dropped when full
    // New read request, not the one being acked right now
    assign do_pop  = wb_cyc && wb_stb && !wb_ack && !empty;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= packet_in;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge CLOCK_50) begin
        if (do_pop) begin
            wb_dat <= mem[rd_ptr];
        end
    end

endmodule

// ==== hdl/mouse_packet_assembler.sv ====
`timescale 1ns/10ps

module mouse_packet_assembler (
    input  logic                        CLOCK_50,
    input  logic                        reset,
    input  logic [7:0]                  byte_data,
    input  logic                        byte_valid,
    output logic                        push,
    output mouse_pad_pkg::mouse_packet_t packet_in
);

    logic [1:0] byte_idx;  // Which byte of the packet comes next
    logic [7:0] status;    // Byte 0 with buttons and sign bits
    logic [7:0] x_mag;     // Byte 1
    logic       marker_ok;

    // Status byte always has bit 3 set
    assign marker_ok = byte_data[3];

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            byte_idx <= 2'd0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            if (byte_valid) begin
                case (byte_idx)
                    2'd0: begin
                        // Stay here until a plausible status byte shows up
                        if (marker_ok) begin
                            byte_idx <= 2'd1;
                        end
                    end
                    2'd1: begin
                        byte_idx <= 2'd2;
                    end
                    default: begin
                        byte_idx <= 2'd0;
                        push     <= 1'b1;  // Packet complete
                    end
                endcase
            end
        end
    end

    // Payload capture
    always_ff @(posedge CLOCK_50) begin
        if (byte_valid) begin
            if (byte_idx == 2'd0 && marker_ok) begin
                status <= byte_data;
            end
            if (byte_idx == 2'd1) begin
                x_mag <= byte_data;
            end
        end
    end

    // Build the packet when byte 2 lands
    always_ff @(posedge CLOCK_50) begin
        if (byte_valid && byte_idx == 2'd2) begin
            packet_in.left <= status[0];
            packet_in.dx   <= {status[4], x_mag};      // 9-bit two's complement
            packet_in.dy   <= {status[5], byte_data};
        end
    end

endmodule

// ==== hdl/ps2_receiver.sv ====
`timescale 1ns/10ps

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] byte_data,
    output logic       byte_valid,
    output logic       frame_error
);

    logic [1:0] clk_sync;   // Two-flop synchronizer for the PS/2 clock
    logic [1:0] data_sync;  // Same for the data line
    logic       clk_prev;   // Delayed copy for edge detection
    logic       ps2_fall;
    logic [3:0] bit_cnt;    // Bits received so far in this frame
    logic [9:0] shift_reg;  // Start, 8 data bits, parity
    logic       start_ok;
    logic       parity_ok;
    logic       stop_ok;

    // Both lines idle high
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // Device changes data on the rising edge, so sample on the falling one
    assign ps2_fall = clk_prev & ~clk_sync[1];

    // Frame checks, valid when the stop bit arrives
    assign start_ok  = ~shift_reg[0];
    assign parity_ok = ^shift_reg[9:1];  // Odd parity over data and parity bit
    assign stop_ok   = data_sync[1];

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (ps2_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;  // Next fall starts a new frame either way
                    if (start_ok && parity_ok && stop_ok) begin
                        byte_valid <= 1'b1;
                    end else begin
                        frame_error <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge CLOCK_50) begin
        if (ps2_fall && bit_cnt != 4'd10) begin
            shift_reg <= {data_sync[1], shift_reg[9:1]};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (ps2_fall && bit_cnt == 4'd10) begin
            byte_data <= shift_reg[8:1];
        end
    end

endmodule

// ==== hdl/mouse_pad_pkg.sv ====
package mouse_pad_pkg;

    // One movement report from the mouse, as it sits in the FIFO
    typedef struct packed {
        logic              left;  // Left button held
        logic signed [8:0] dx;    // Sign from status bit 4
        logic signed [8:0] dy;    // Sign from status bit 5
    } mouse_packet_t;

    // Screen size in pixels
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // Canvas placement on the screen
    localparam int GRID_SIZE   = 28;  // Cells per side
    localparam int PIXEL_SCALE = 2;   // Screen pixels per cell side
    localparam int GRID_X0     = 52;
    localparam int GRID_Y0     = 32;

    // Cursor start position, centre of the screen
    localparam int CURSOR_X0 = 80;
    localparam int CURSOR_Y0 = 60;

    // 3-bit RGB colour codes
    localparam logic [2:0] COLOUR_CURSOR = 3'b100;  // Red
    localparam logic [2:0] COLOUR_INK    = 3'b000;  // Black
    localparam logic [2:0] COLOUR_PAPER  = 3'b111;  // White

endpackage
